/* hdl/nes_io_pkg.sv */
/*
 * shared widths for the softcore bridge and controller port
 * console button and gamepad bit positions
 * word plan and sequencer state enums
 */
package nes_io_pkg;

    ////////////////////
    // bus widths
    ////////////////////
    localparam int RV_ADDR_W  = 23;     // softcore byte address
    localparam int RV_DATA_W  = 32;
    localparam int RV_STRB_W  = 4;
    localparam int HALF_W     = 16;     // memory port data
    localparam int DS_W       = 2;      // memory byte selects
    localparam int JOY_BYTE_W = 8;
    localparam int NES_BTN_W  = 8;

    ////////////////////
    // console buttons, shifted out A first
    ////////////////////
    localparam int BTN_A      = 0;
    localparam int BTN_B      = 1;
    localparam int BTN_SELECT = 2;
    localparam int BTN_START  = 3;
    localparam int BTN_UP     = 4;
    localparam int BTN_DOWN   = 5;
    localparam int BTN_LEFT   = 6;
    localparam int BTN_RIGHT  = 7;

    // gamepad byte 0, active low
    localparam int PAD0_SELECT = 0;
    localparam int PAD0_START  = 3;
    localparam int PAD0_UP     = 4;
    localparam int PAD0_RIGHT  = 5;
    localparam int PAD0_DOWN   = 6;
    localparam int PAD0_LEFT   = 7;
    // gamepad byte 1, active low
    localparam int PAD1_CIRCLE = 5;
    localparam int PAD1_CROSS  = 6;

    // halves touched by one softcore access
    typedef enum logic [1:0] {
        PLAN_BOTH,
        PLAN_LOW_ONLY,
        PLAN_HIGH_ONLY
    } word_plan_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_WAIT0,      // low half in flight
        SEQ_DATA0,      // low read half on i_mem_dout
        SEQ_WAIT1,      // high half in flight
        SEQ_DATA1
    } seq_state_e;

endpackage

/* hdl/rv_req_decode.sv */
/*
 * softcore request edge detect with one pending slot
 * strobe decode into word plan and byte selects
 */
`timescale 1ns/10ps

module rv_req_decode import nes_io_pkg::*; (
    input  logic                 clk,
    input  logic                 sys_resetn,
    input  logic                 i_rv_valid,
    input  logic [RV_STRB_W-1:0] i_rv_wstrb,
    input  logic                 i_accept,
    output logic                 o_start,
    output word_plan_e           o_plan,
    output logic [DS_W-1:0]      o_ds_low,
    output logic [DS_W-1:0]      o_ds_high,
    output logic                 o_write
);

    logic            valid_r;
    logic            pending;
    logic            rise;
    logic            is_write;
    logic [DS_W-1:0] strb_lo;
    logic [DS_W-1:0] strb_hi;
    word_plan_e      plan_d;

    assign rise     = i_rv_valid & ~valid_r;
    assign strb_lo  = i_rv_wstrb[DS_W-1:0];
    assign strb_hi  = i_rv_wstrb[RV_STRB_W-1:DS_W];
    assign is_write = |i_rv_wstrb;              // no strobes means read

    always_comb begin
        plan_d = PLAN_BOTH;                     // all reads use both halves
        if (is_write && strb_lo == '0)
            plan_d = PLAN_HIGH_ONLY;
        else if (is_write && strb_hi == '0)
            plan_d = PLAN_LOW_ONLY;
    end

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            valid_r <= 1'b0;
            pending <= 1'b0;
        end else begin
            valid_r <= i_rv_valid;
            if (rise)
                pending <= 1'b1;                // a new edge replaces an accepted one
            else if (i_accept)
                pending <= 1'b0;
        end
    end

    // request description, held until the next edge
    always_ff @(posedge clk) begin
        if (rise) begin
            o_plan    <= plan_d;
            o_write   <= is_write;
            o_ds_low  <= is_write ? strb_lo : '1;
            o_ds_high <= is_write ? strb_hi : '1;
        end
    end

    assign o_start = pending;

    // the softcore never issues a second edge over an unaccepted request
    a_no_overrun: assert property (@(posedge clk) disable iff (!sys_resetn)
        rise |-> (!pending || i_accept))
        else $error("request edge while previous request still pending");

endmodule

/* hdl/rv_word_sequencer.sv */
/*
 * issues one or two 16-bit accesses per softcore request
 * on the toggle request/acknowledge memory port
 */
`timescale 1ns/10ps

module rv_word_sequencer import nes_io_pkg::*; #(
    parameter int MEM_ADDR_W = 20
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_start,
    input  word_plan_e            i_plan,
    input  logic [DS_W-1:0]       i_ds_low,
    input  logic [DS_W-1:0]       i_ds_high,
    input  logic                  i_write,
    input  logic [RV_ADDR_W-1:0]  i_rv_addr,
    input  logic [RV_DATA_W-1:0]  i_rv_wdata,
    input  logic                  i_mem_req_ack,
    output logic                  o_accept,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    output logic [HALF_W-1:0]     o_mem_din,
    output logic [DS_W-1:0]       o_mem_ds,
    output logic                  o_mem_we,
    output logic                  o_mem_req,
    output logic                  o_cap_low,
    output logic                  o_cap_high,
    output logic                  o_write_done
);

    seq_state_e      state;
    word_plan_e      plan_q;
    logic [DS_W-1:0] ds_high_q;
    logic            half;          // 1 while the upper half is addressed
    logic            done;          // acknowledge caught up with request

    assign done = (i_mem_req_ack == o_mem_req);

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state     <= SEQ_IDLE;
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: if (i_start) begin
                    o_mem_req <= ~o_mem_req;
                    o_mem_we  <= i_write;
                    state     <= (i_plan == PLAN_HIGH_ONLY) ? SEQ_WAIT1 : SEQ_WAIT0;
                end
                SEQ_WAIT0: if (done) begin
                    if (!o_mem_we) begin
                        state <= SEQ_DATA0;
                    end else if (plan_q == PLAN_LOW_ONLY) begin
                        state <= SEQ_IDLE;          // upper access skipped
                    end else begin
                        o_mem_req <= ~o_mem_req;
                        state     <= SEQ_WAIT1;
                    end
                end
                SEQ_DATA0: begin
                    o_mem_req <= ~o_mem_req;        // low half captured, fetch high
                    state     <= SEQ_WAIT1;
                end
                SEQ_WAIT1: if (done)
                    state <= o_mem_we ? SEQ_IDLE : SEQ_DATA1;
                SEQ_DATA1: state <= SEQ_IDLE;
                default:   state <= SEQ_IDLE;
            endcase
        end
    end

    // half select and byte selects follow each toggle
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && i_start) begin
            plan_q    <= i_plan;
            ds_high_q <= i_ds_high;
            half      <= (i_plan == PLAN_HIGH_ONLY);
            o_mem_ds  <= (i_plan == PLAN_HIGH_ONLY) ? i_ds_high : i_ds_low;
        end else if ((state == SEQ_WAIT0 && done && o_mem_we) || state == SEQ_DATA0) begin
            half     <= 1'b1;
            o_mem_ds <= ds_high_q;
        end
    end

    assign o_accept   = (state == SEQ_IDLE) & i_start;
    assign o_mem_addr = {i_rv_addr[MEM_ADDR_W:2], half};
    assign o_mem_din  = half ? i_rv_wdata[RV_DATA_W-1:HALF_W] : i_rv_wdata[HALF_W-1:0];
    assign o_cap_low  = (state == SEQ_DATA0);
    assign o_cap_high = (state == SEQ_DATA1);

    // last write half acknowledged
    assign o_write_done = o_mem_we & done &
                          ((state == SEQ_WAIT0 && plan_q == PLAN_LOW_ONLY) ||
                           state == SEQ_WAIT1);

    // a new access only starts once the memory has answered the last one
    a_req_toggle: assert property (@(posedge clk) disable iff (!sys_resetn)
        (o_mem_req != $past(o_mem_req)) |-> ($past(i_mem_req_ack) == $past(o_mem_req)))
        else $error("memory request toggled before acknowledge");

endmodule

/* hdl/rv_read_assemble.sv */
/*
 * joins the two returned halves into the softcore read word
 * and pulses ready at the end of each request
 */
`timescale 1ns/10ps

module rv_read_assemble import nes_io_pkg::*; (
    input  logic                 clk,
    input  logic                 sys_resetn,
    input  logic                 i_cap_low,
    input  logic                 i_cap_high,
    input  logic                 i_write_done,
    input  logic [HALF_W-1:0]    i_mem_dout,
    output logic [RV_DATA_W-1:0] o_rv_rdata,
    output logic                 o_rv_ready
);

    logic [HALF_W-1:0] rdata_lo;
    logic [HALF_W-1:0] rdata_hi;

    ////////////////////
    // read halves
    ////////////////////
    always_ff @(posedge clk) begin
        if (i_cap_low)
            rdata_lo <= i_mem_dout;
        if (i_cap_high)
            rdata_hi <= i_mem_dout;
    end

    assign o_rv_rdata = {rdata_hi, rdata_lo};

    // one cycle after the last half
    always_ff @(posedge clk) begin
        if (!sys_resetn)
            o_rv_ready <= 1'b0;
        else
            o_rv_ready <= i_cap_high | i_write_done;
    end

    // each request ends with exactly one ready cycle
    a_ready_pulse: assert property (@(posedge clk) disable iff (!sys_resetn)
        o_rv_ready |=> !o_rv_ready)
        else $error("ready held for more than one cycle");

endmodule

/* hdl/joypad_port.sv */
/*
 * gamepad byte to console button mapping for two players
 * strobe latch and serial shift-out per joypad clock
 */
`timescale 1ns/10ps

module joypad_port import nes_io_pkg::*; (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic [JOY_BYTE_W-1:0] i_joy0_b0,
    input  logic [JOY_BYTE_W-1:0] i_joy0_b1,
    input  logic [JOY_BYTE_W-1:0] i_joy1_b0,
    input  logic [JOY_BYTE_W-1:0] i_joy1_b1,
    input  logic                  i_joypad_strobe,
    input  logic [1:0]            i_joypad_clock,
    output logic [1:0]            o_joypad_data
);

    logic [1:0][NES_BTN_W-1:0] btn;
    logic [1:0][NES_BTN_W-1:0] shift;
    logic                      strobe_q;
    logic [1:0]                clock_q;
    logic [1:0]                fall_q;

    // gamepad bits are active low, console buttons active high
    function automatic logic [NES_BTN_W-1:0] map_pad(
        input logic [JOY_BYTE_W-1:0] b0,
        input logic [JOY_BYTE_W-1:0] b1
    );
        logic [NES_BTN_W-1:0] m;
        m             = '0;
        m[BTN_RIGHT]  = ~b0[PAD0_RIGHT];
        m[BTN_LEFT]   = ~b0[PAD0_LEFT];
        m[BTN_DOWN]   = ~b0[PAD0_DOWN];
        m[BTN_UP]     = ~b0[PAD0_UP];
        m[BTN_START]  = ~b0[PAD0_START];
        m[BTN_SELECT] = ~b0[PAD0_SELECT];
        m[BTN_B]      = ~b1[PAD1_CROSS];
        m[BTN_A]      = ~b1[PAD1_CIRCLE];
        return m;
    endfunction

    assign btn[0] = map_pad(i_joy0_b0, i_joy0_b1);
    assign btn[1] = map_pad(i_joy1_b0, i_joy1_b1);

    ////////////////////
    // edge tracking
    ////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            strobe_q <= 1'b0;
            clock_q  <= '0;
            fall_q   <= '0;
        end else begin
            strobe_q <= i_joypad_strobe;
            clock_q  <= i_joypad_clock;
            fall_q   <= clock_q & ~i_joypad_clock;     // falling edge per player
        end
    end

    ////////////////////
    // shift registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            shift <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (fall_q[p])
                    shift[p] <= {1'b0, shift[p][NES_BTN_W-1:1]};    // shift beats load
                else if (strobe_q)
                    shift[p] <= btn[p];
            end
        end
    end

    assign o_joypad_data = {shift[1][0], shift[0][0]};

endmodule

/* hdl/nes_io_top.sv */
/*
 * console io top level
 * softcore memory bridge and two-player controller port
 */
`timescale 1ns/10ps

module nes_io_top import nes_io_pkg::*; #(
    parameter int MEM_ADDR_W = 20
) (
    input  logic                  clk,
    input  logic                  sys_resetn,

    // softcore bus
    input  logic                  i_rv_valid,
    input  logic [RV_ADDR_W-1:0]  i_rv_addr,
    input  logic [RV_DATA_W-1:0]  i_rv_wdata,
    input  logic [RV_STRB_W-1:0]  i_rv_wstrb,
    output logic                  o_rv_ready,
    output logic [RV_DATA_W-1:0]  o_rv_rdata,

    // 16-bit memory port
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    output logic [HALF_W-1:0]     o_mem_din,
    output logic [DS_W-1:0]       o_mem_ds,
    output logic                  o_mem_we,
    output logic                  o_mem_req,
    input  logic                  i_mem_req_ack,
    input  logic [HALF_W-1:0]     i_mem_dout,

    // gamepads and console joypad lines
    input  logic [JOY_BYTE_W-1:0] i_joy0_b0,
    input  logic [JOY_BYTE_W-1:0] i_joy0_b1,
    input  logic [JOY_BYTE_W-1:0] i_joy1_b0,
    input  logic [JOY_BYTE_W-1:0] i_joy1_b1,
    input  logic                  i_joypad_strobe,
    input  logic [1:0]            i_joypad_clock,
    output logic [1:0]            o_joypad_data
);

    logic            start;
    logic            accept;
    word_plan_e      plan;
    logic [DS_W-1:0] ds_low;
    logic [DS_W-1:0] ds_high;
    logic            write;
    logic            cap_low;
    logic            cap_high;
    logic            write_done;

    ////////////////////
    // softcore bridge
    ////////////////////
    rv_req_decode u_decode (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_wstrb(i_rv_wstrb), .i_accept(accept),
        .o_start(start), .o_plan(plan), .o_ds_low(ds_low), .o_ds_high(ds_high),
        .o_write(write)
    );

    rv_word_sequencer #(.MEM_ADDR_W(MEM_ADDR_W)) u_sequencer (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_start(start), .i_plan(plan), .i_ds_low(ds_low), .i_ds_high(ds_high),
        .i_write(write), .i_rv_addr(i_rv_addr), .i_rv_wdata(i_rv_wdata),
        .i_mem_req_ack(i_mem_req_ack), .o_accept(accept),
        .o_mem_addr(o_mem_addr), .o_mem_din(o_mem_din), .o_mem_ds(o_mem_ds),
        .o_mem_we(o_mem_we), .o_mem_req(o_mem_req),
        .o_cap_low(cap_low), .o_cap_high(cap_high), .o_write_done(write_done)
    );

    rv_read_assemble u_assemble (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_cap_low(cap_low), .i_cap_high(cap_high), .i_write_done(write_done),
        .i_mem_dout(i_mem_dout), .o_rv_rdata(o_rv_rdata), .o_rv_ready(o_rv_ready)
    );

    ////////////////////
    // controller port
    ////////////////////
    joypad_port u_joypad (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_joy0_b0(i_joy0_b0), .i_joy0_b1(i_joy0_b1),
        .i_joy1_b0(i_joy1_b0), .i_joy1_b1(i_joy1_b1),
        .i_joypad_strobe(i_joypad_strobe), .i_joypad_clock(i_joypad_clock),
        .o_joypad_data(o_joypad_data)
    );

endmodule

/* tb/mem16_model.sv */
/*
 * 16-bit memory model on the toggle request/acknowledge port
 * random acknowledge delay of 1 to 6 cycles, access counter
 */
`timescale 1ns/10ps

module mem16_model import nes_io_pkg::*; #(
    parameter int          ADDR_W = 20,
    parameter logic [31:0] SEED   = 32'hf751_1f8c
) (
    input  logic              clk,
    input  logic              sys_resetn,
    input  logic [ADDR_W-1:0] i_mem_addr,
    input  logic [HALF_W-1:0] i_mem_din,
    input  logic [DS_W-1:0]   i_mem_ds,
    input  logic              i_mem_we,
    input  logic              i_mem_req,
    output logic              o_mem_req_ack,
    output logic [HALF_W-1:0] o_mem_dout,
    output logic [31:0]       o_access_cnt
);

    logic [HALF_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [HALF_W-1:0] cur;
    logic [31:0]       wait_cnt;    // cycles left before acknowledge
    logic              busy;
    int                seed = SEED;

    // unwritten words read back a pattern of their full address
    function automatic logic [HALF_W-1:0] fill(input logic [ADDR_W-1:0] a);
        return a[HALF_W-1:0] ^ HALF_W'(a >> HALF_W) ^ 16'h6b3d;
    endfunction

    always @(posedge clk) begin
        if (!sys_resetn) begin
            o_mem_req_ack <= 1'b0;
            o_mem_dout    <= '0;
            o_access_cnt  <= '0;
            wait_cnt      <= '0;
            busy          <= 1'b0;
        end else if (!busy) begin
            if (i_mem_req != o_mem_req_ack) begin     // request toggled
                busy     <= 1'b1;
                wait_cnt <= {$random(seed)} % 6;
            end
        end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            cur = mem.exists(i_mem_addr) ? mem[i_mem_addr] : fill(i_mem_addr);
            if (i_mem_we) begin
                if (i_mem_ds[0])
                    cur[7:0] = i_mem_din[7:0];
                if (i_mem_ds[1])
                    cur[15:8] = i_mem_din[15:8];
                mem[i_mem_addr] = cur;
            end else begin
                o_mem_dout <= cur;                     // held until the next read
            end
            o_mem_req_ack <= i_mem_req;
            o_access_cnt  <= o_access_cnt + 1;
            busy          <= 1'b0;
        end
    end

endmodule

/* tb/nes_io_tb.sv */
/*
 * testbench for the console io top level
 * directed bridge and joypad tests against the 16-bit memory model
 */
`timescale 1ns/10ps

module nes_io_tb import nes_io_pkg::*; ();

    localparam int          MEM_ADDR_W    = 20;
    localparam int          READY_TIMEOUT = 200;
    localparam logic [31:0] SEED          = 32'hf751_1f8c;

    logic                  clk;
    logic                  sys_resetn;
    logic                  rv_valid;
    logic [RV_ADDR_W-1:0]  rv_addr;
    logic [RV_DATA_W-1:0]  rv_wdata;
    logic [RV_STRB_W-1:0]  rv_wstrb;
    logic                  rv_ready;
    logic [RV_DATA_W-1:0]  rv_rdata;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [HALF_W-1:0]     mem_din;
    logic [HALF_W-1:0]     mem_dout;
    logic [DS_W-1:0]       mem_ds;
    logic                  mem_we;
    logic                  mem_req;
    logic                  mem_req_ack;
    logic [31:0]           access_cnt;
    logic [JOY_BYTE_W-1:0] joy0_b0;
    logic [JOY_BYTE_W-1:0] joy0_b1;
    logic [JOY_BYTE_W-1:0] joy1_b0;
    logic [JOY_BYTE_W-1:0] joy1_b1;
    logic                  joypad_strobe;
    logic [1:0]            joypad_clock;
    logic [1:0]            joypad_data;
    int                    seed = SEED;
    int                    errors;
    int                    test_errors;     // error count when the test began
    int                    tests_run;
    int                    tests_failed;
    string                 cur_test;

    initial clk = 1'b0;
    always #20 clk = ~clk;                  // 40 ns period

    nes_io_top #(.MEM_ADDR_W(MEM_ADDR_W)) u_dut (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(rv_valid), .i_rv_addr(rv_addr), .i_rv_wdata(rv_wdata),
        .i_rv_wstrb(rv_wstrb), .o_rv_ready(rv_ready), .o_rv_rdata(rv_rdata),
        .o_mem_addr(mem_addr), .o_mem_din(mem_din), .o_mem_ds(mem_ds),
        .o_mem_we(mem_we), .o_mem_req(mem_req),
        .i_mem_req_ack(mem_req_ack), .i_mem_dout(mem_dout),
        .i_joy0_b0(joy0_b0), .i_joy0_b1(joy0_b1),
        .i_joy1_b0(joy1_b0), .i_joy1_b1(joy1_b1),
        .i_joypad_strobe(joypad_strobe), .i_joypad_clock(joypad_clock),
        .o_joypad_data(joypad_data)
    );

    mem16_model #(.ADDR_W(MEM_ADDR_W), .SEED(SEED)) u_mem (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_mem_addr(mem_addr), .i_mem_din(mem_din), .i_mem_ds(mem_ds),
        .i_mem_we(mem_we), .i_mem_req(mem_req), .o_mem_req_ack(mem_req_ack),
        .o_mem_dout(mem_dout), .o_access_cnt(access_cnt)
    );

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_word(input string what, input logic [RV_DATA_W-1:0] exp,
                              input logic [RV_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s/%s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_half(input string what, input logic [HALF_W-1:0] exp,
                              input logic [HALF_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s/%s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s/%s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", cur_test, errors - test_errors);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rv_ready && n < READY_TIMEOUT);
        if (!rv_ready) begin
            $display("error in %s: no ready within %0d cycles", cur_test, READY_TIMEOUT);
            errors++;
        end
    endtask

    // one softcore request with valid dropped again at ready
    task automatic bus_access(input logic [RV_ADDR_W-1:0] addr,
                              input logic [RV_DATA_W-1:0] wdata,
                              input logic [RV_STRB_W-1:0] wstrb,
                              output logic [RV_DATA_W-1:0] rdata);
        @(negedge clk);
        rv_addr  = addr;
        rv_wdata = wdata;
        rv_wstrb = wstrb;
        rv_valid = 1'b1;
        wait_ready();
        rdata    = rv_rdata;
        rv_valid = 1'b0;
    endtask

    // inverted gamepad bits in console order from RIGHT down to A
    function automatic logic [NES_BTN_W-1:0] expected_buttons(
        input logic [JOY_BYTE_W-1:0] b0, input logic [JOY_BYTE_W-1:0] b1);
        return ~{b0[PAD0_RIGHT], b0[PAD0_LEFT], b0[PAD0_DOWN], b0[PAD0_UP],
                 b0[PAD0_START], b0[PAD0_SELECT], b1[PAD1_CROSS], b1[PAD1_CIRCLE]};
    endfunction

    ////////////////////
    // directed tests
    ////////////////////
    task automatic test_reset();
        start_test("reset");
        check_bit("ready", 1'b0, rv_ready);
        check_bit("mem_req", 1'b0, mem_req);
        check_bit("joy0 data", 1'b0, joypad_data[0]);
        check_bit("joy1 data", 1'b0, joypad_data[1]);
        end_test();
    endtask

    task automatic test_write_read();
        logic [RV_DATA_W-1:0] rd;
        start_test("write_read");
        bus_access(23'h00_1000, 32'hcafe_1234, 4'hf, rd);
        bus_access(23'h00_1000, 32'h0, 4'h0, rd);
        check_word("read back", 32'hcafe_1234, rd);
        end_test();
    endtask

    task automatic test_half_writes();
        logic [RV_DATA_W-1:0] rd;
        logic [31:0]          cnt;
        start_test("half_writes");
        bus_access(23'h01_2a48, 32'ha5a5_5a5a, 4'hf, rd);
        cnt = access_cnt;
        bus_access(23'h01_2a48, 32'hbeef_1357, 4'h4, rd);     // byte 2 in the upper half
        check_word("upper write accesses", 32'd1, access_cnt - cnt);
        bus_access(23'h01_2a48, 32'h0, 4'h0, rd);
        check_half("upper written", 16'ha5ef, rd[31:16]);
        check_half("lower kept", 16'h5a5a, rd[15:0]);
        cnt = access_cnt;
        bus_access(23'h01_2a48, 32'h2468_c0de, 4'h2, rd);     // byte 1 in the lower half
        check_word("lower write accesses", 32'd1, access_cnt - cnt);
        bus_access(23'h01_2a48, 32'h0, 4'h0, rd);
        check_half("upper kept", 16'ha5ef, rd[31:16]);
        check_half("lower written", 16'hc05a, rd[15:0]);
        end_test();
    endtask

    task automatic test_back_to_back();
        logic [RV_DATA_W-1:0] rd;
        logic [RV_DATA_W-1:0] data [8];
        logic [RV_ADDR_W-1:0] base;
        logic                 req0;
        int                   n;
        start_test("back_to_back");
        base = {2'b00, 16'($random(seed)), 5'b0};
        for (int i = 0; i < 8; i++) begin
            data[i] = $random(seed);
            bus_access(base + 23'(i * 4), data[i], 4'hf, rd);
        end
        for (int i = 7; i >= 0; i--) begin
            bus_access(base + 23'(i * 4), 32'h0, 4'h0, rd);
            check_word($sformatf("word %0d", i), data[i], rd);
        end
        // a read edge arrives while the full write is still in flight
        data[0] = ~data[0];
        @(negedge clk);
        req0     = mem_req;
        rv_addr  = base;
        rv_wdata = data[0];
        rv_wstrb = 4'hf;
        rv_valid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (mem_req == req0 && n < READY_TIMEOUT);
        if (mem_req == req0) begin
            $display("error in %s: first request never reached the memory", cur_test);
            errors++;
        end
        rv_valid = 1'b0;
        @(negedge clk);
        rv_wstrb = 4'h0;
        rv_valid = 1'b1;
        wait_ready();           // the write
        wait_ready();           // the pending read
        rd       = rv_rdata;
        rv_valid = 1'b0;
        check_word("overlapped read", data[0], rd);
        end_test();
    endtask

    task automatic test_joypad();
        logic [NES_BTN_W-1:0] exp0;
        logic [NES_BTN_W-1:0] exp1;
        start_test("joypad");
        @(negedge clk);
        joy0_b0       = 8'h5a;
        joy0_b1       = 8'hbd;
        joy1_b0       = 8'h96;
        joy1_b1       = 8'h3c;
        exp0          = expected_buttons(8'h5a, 8'hbd);
        exp1          = expected_buttons(8'h96, 8'h3c);
        joypad_strobe = 1'b1;
        @(negedge clk);
        joypad_strobe = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            check_bit($sformatf("p0 bit %0d", i), exp0[0], joypad_data[0]);
            check_bit($sformatf("p1 bit %0d", i), exp1[0], joypad_data[1]);
            exp0         = exp0 >> 1;       // zeros follow RIGHT
            exp1         = exp1 >> 1;
            joypad_clock = 2'b11;
            @(negedge clk);
            joypad_clock = 2'b00;
            @(negedge clk);
            @(negedge clk);
        end
        end_test();
    endtask

    initial begin
        sys_resetn    = 1'b0;
        rv_valid      = 1'b0;
        rv_addr       = '0;
        rv_wdata      = '0;
        rv_wstrb      = '0;
        joy0_b0       = 8'hff;      // nothing pressed
        joy0_b1       = 8'hff;
        joy1_b0       = 8'hff;
        joy1_b1       = 8'hff;
        joypad_strobe = 1'b0;
        joypad_clock  = 2'b00;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        test_reset();
        test_write_read();
        test_half_writes();
        test_back_to_back();
        test_joypad();
        $display("tests run %0d, failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/nes_io_pkg.sv
hdl/rv_req_decode.sv
hdl/rv_word_sequencer.sv
hdl/rv_read_assemble.sv
hdl/joypad_port.sv
hdl/nes_io_top.sv
tb/mem16_model.sv
tb/nes_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the console io testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -sv -f build.f \
    --top-module nes_io_tb -Mdir obj_dir -o nes_io_sim
./obj_dir/nes_io_sim | tee "$LOG"

if grep -qx '\*\*\* PASSED \*\*\*' "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
